/* all.f */
source/sparc_ctrl_pkg.sv
source/alu_op_decoder.sv
source/mem_op_decoder.sv
source/control_unit.sv
testbench/control_unit_props.sv
testbench/control_unit_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module control_unit_tb -f all.f -o control_unit_sim

# error limit raised so that assertion failures reach the closing report
./obj_dir/control_unit_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
exit 0

/* source/alu_op_decoder.sv */
module alu_op_decoder import sparc_ctrl_pkg::*; (
    input  instr_t fmt3,
    output ctrl_t  fields
);

    logic [OP3_W-1:0] op3;
    logic [ALU_W-1:0] alu_code;
    logic             is_arith;   // op3 is one of the listed ALU ops
    logic             sets_cc;

    assign op3 = fmt3.fmt3.op3;

    // ALU code, plain and cc forms share it
    always_comb begin
        alu_code = ALU_ADD;
        is_arith = 1'b1;
        case (op3)
            OP3_ADD, OP3_ADDCC: alu_code = ALU_ADD;
            OP3_ADDX, OP3_ADDXCC: alu_code = ALU_ADDX;
            OP3_SUB, OP3_SUBCC: alu_code = ALU_SUB;
            OP3_SUBX: alu_code = ALU_SUBX;   // no subxcc here
            OP3_AND, OP3_ANDCC: alu_code = ALU_AND;
            OP3_ANDN, OP3_ANDNCC: alu_code = ALU_ANDN;
            OP3_OR, OP3_ORCC: alu_code = ALU_OR;
            OP3_ORN, OP3_ORNCC: alu_code = ALU_ORN;
            OP3_XOR, OP3_XORCC: alu_code = ALU_XOR;
            OP3_XNOR, OP3_XNORCC: alu_code = ALU_XNOR;
            OP3_SLL: alu_code = ALU_SLL;
            OP3_SRL: alu_code = ALU_SRL;
            OP3_SRA: alu_code = ALU_SRA;
            default: is_arith = 1'b0;
        endcase
    end

    // condition code forms
    always_comb begin
        case (op3)
            OP3_ADDCC,
            OP3_ADDXCC,
            OP3_SUBCC,
            OP3_ANDCC,
            OP3_ANDNCC,
            OP3_ORCC,
            OP3_ORNCC,
            OP3_XORCC,
            OP3_XNORCC: sets_cc = 1'b1;
            default:    sets_cc = 1'b0;
        endcase
    end

    always_comb begin
        fields = '0;
        case (op3)
            OP3_JMPL: begin
                fields.jmpl = 1'b1;   // target computed in the ALU path
            end
            OP3_SAVE,
            OP3_RESTORE: begin
                // window switch writes the register file
                fields.rf_enable  = 1'b1;
                fields.mem_enable = 1'b1;
                fields.mem_size   = SIZE_WORD;
            end
            default: begin
                if (is_arith) begin
                    fields.alu_op    = alu_code;
                    fields.cc_enable = sets_cc;
                end
            end
        endcase
    end

endmodule

/* source/control_unit.sv */
module control_unit import sparc_ctrl_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  instr_t instr,
    input  logic   bubble,
    output ctrl_t  ctrl
);

    ctrl_t alu_fields;   // from op = 10 decoder
    ctrl_t mem_fields;   // from op = 11 decoder
    ctrl_t next_ctrl;
    ctrl_t ctrl_q;
    logic  is_nop;

    alu_op_decoder u_alu_dec (
        .fmt3   (instr),
        .fields (alu_fields)
    );

    mem_op_decoder u_mem_dec (
        .fmt3   (instr),
        .fields (mem_fields)
    );

    assign is_nop = (instr == '0);

    // format selection
    always_comb begin
        next_ctrl = '0;
        if (!is_nop) begin
            case (instr.fmt1.op)
                OP_BRANCH_SETHI: begin
                    case (instr.fmt2.op2)
                        OP2_SETHI:  next_ctrl.alu_op = ALU_PASS_B;   // imm22 goes through B
                        OP2_BRANCH: next_ctrl.branch = 1'b1;
                        default:    next_ctrl = '0;
                    endcase
                end
                OP_CALL: begin
                    // return address lands in r15
                    next_ctrl.call      = 1'b1;
                    next_ctrl.rf_enable = 1'b1;
                end
                OP_ARITH: next_ctrl = alu_fields;
                OP_MEM:   next_ctrl = mem_fields;
            endcase
        end

        // raw bits ride along for the later stages
        next_ctrl.i31 = instr.fmt1.op[1];
        next_ctrl.i30 = instr.fmt1.op[0];
        next_ctrl.i24 = instr.fmt3.op3[OP3_W-1];
        next_ctrl.i13 = instr.fmt3.i;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_q <= '0;
        end else begin
            ctrl_q <= next_ctrl;   // loads even during a bubble
        end
    end

    // bubble squashes the registered bundle in the same cycle
    assign ctrl = bubble ? '0 : ctrl_q;

endmodule

/* source/mem_op_decoder.sv */
module mem_op_decoder import sparc_ctrl_pkg::*; (
    input  instr_t fmt3,
    output ctrl_t  fields
);

    logic hit;   // op3 is a known load or store

    always_comb begin
        fields = '0;
        hit    = 1'b1;
        case (fmt3.fmt3.op3)
            // loads read memory, rw stays 0
            OP3_LDSB: begin
                fields.load     = 1'b1;
                fields.mem_se   = 1'b1;
                fields.mem_size = SIZE_BYTE;
            end
            OP3_LDSH: begin
                fields.load     = 1'b1;
                fields.mem_se   = 1'b1;
                fields.mem_size = SIZE_HALF;
            end
            OP3_LD: begin
                fields.load     = 1'b1;
                fields.mem_size = SIZE_WORD;
            end
            OP3_LDUB: begin
                fields.load     = 1'b1;
                fields.mem_size = SIZE_BYTE;   // zero extended
            end
            OP3_LDUH: begin
                fields.load     = 1'b1;
                fields.mem_size = SIZE_HALF;
            end
            // stores write memory, never sign extended
            OP3_STB: begin
                fields.mem_rw   = 1'b1;
                fields.mem_size = SIZE_BYTE;
            end
            OP3_STH: begin
                fields.mem_rw   = 1'b1;
                fields.mem_size = SIZE_HALF;
            end
            OP3_ST: begin
                fields.mem_rw   = 1'b1;
                fields.mem_size = SIZE_WORD;
            end
            default: hit = 1'b0;
        endcase

        // enables common to every listed access
        fields.mem_enable = hit;
        fields.rf_enable  = hit;
    end

endmodule

/* source/sparc_ctrl_pkg.sv */
package sparc_ctrl_pkg;

    // instruction field widths
    localparam int OP_W     = 2;
    localparam int OP2_W    = 3;
    localparam int OP3_W    = 6;
    localparam int REG_W    = 5;
    localparam int DISP30_W = 30;
    localparam int IMM22_W  = 22;
    localparam int LOW13_W  = 13;

    // control bundle field widths
    localparam int ALU_W  = 4;
    localparam int SIZE_W = 2;

    // format codes, bits 31:30
    localparam logic [OP_W-1:0] OP_BRANCH_SETHI = 2'b00;
    localparam logic [OP_W-1:0] OP_CALL         = 2'b01;
    localparam logic [OP_W-1:0] OP_ARITH        = 2'b10;
    localparam logic [OP_W-1:0] OP_MEM          = 2'b11;

    // op2 of format 2
    localparam logic [OP2_W-1:0] OP2_SETHI  = 3'b100;
    localparam logic [OP2_W-1:0] OP2_BRANCH = 3'b010;

    // op3 arithmetic, op = 10
    localparam logic [OP3_W-1:0] OP3_ADD    = 6'b000000;
    localparam logic [OP3_W-1:0] OP3_ADDCC  = 6'b010000;
    localparam logic [OP3_W-1:0] OP3_ADDX   = 6'b001000;
    localparam logic [OP3_W-1:0] OP3_ADDXCC = 6'b011000;
    localparam logic [OP3_W-1:0] OP3_SUB    = 6'b000100;
    localparam logic [OP3_W-1:0] OP3_SUBCC  = 6'b010100;
    localparam logic [OP3_W-1:0] OP3_SUBX   = 6'b001100;
    localparam logic [OP3_W-1:0] OP3_AND    = 6'b000001;
    localparam logic [OP3_W-1:0] OP3_ANDCC  = 6'b010001;
    localparam logic [OP3_W-1:0] OP3_ANDN   = 6'b000101;
    localparam logic [OP3_W-1:0] OP3_ANDNCC = 6'b010101;
    localparam logic [OP3_W-1:0] OP3_OR     = 6'b000010;
    localparam logic [OP3_W-1:0] OP3_ORCC   = 6'b010010;
    localparam logic [OP3_W-1:0] OP3_ORN    = 6'b000110;
    localparam logic [OP3_W-1:0] OP3_ORNCC  = 6'b010110;
    localparam logic [OP3_W-1:0] OP3_XOR    = 6'b000011;
    localparam logic [OP3_W-1:0] OP3_XORCC  = 6'b010011;
    localparam logic [OP3_W-1:0] OP3_XNOR   = 6'b000111;
    localparam logic [OP3_W-1:0] OP3_XNORCC = 6'b010111;
    localparam logic [OP3_W-1:0] OP3_SLL    = 6'b100101;
    localparam logic [OP3_W-1:0] OP3_SRL    = 6'b100110;
    localparam logic [OP3_W-1:0] OP3_SRA    = 6'b100111;

    // control transfer and register windows
    localparam logic [OP3_W-1:0] OP3_JMPL    = 6'b111000;
    localparam logic [OP3_W-1:0] OP3_SAVE    = 6'b111100;
    localparam logic [OP3_W-1:0] OP3_RESTORE = 6'b111101;

    // op3 load/store, op = 11
    localparam logic [OP3_W-1:0] OP3_LDSB = 6'b001001;
    localparam logic [OP3_W-1:0] OP3_LDSH = 6'b001010;
    localparam logic [OP3_W-1:0] OP3_LD   = 6'b000000;
    localparam logic [OP3_W-1:0] OP3_LDUB = 6'b000001;
    localparam logic [OP3_W-1:0] OP3_LDUH = 6'b000010;
    localparam logic [OP3_W-1:0] OP3_STB  = 6'b000101;
    localparam logic [OP3_W-1:0] OP3_STH  = 6'b000110;
    localparam logic [OP3_W-1:0] OP3_ST   = 6'b000100;

    // ALU operation codes
    localparam logic [ALU_W-1:0] ALU_ADD    = 4'b0000;
    localparam logic [ALU_W-1:0] ALU_ADDX   = 4'b0001;
    localparam logic [ALU_W-1:0] ALU_SUB    = 4'b0010;
    localparam logic [ALU_W-1:0] ALU_SUBX   = 4'b0011;
    localparam logic [ALU_W-1:0] ALU_AND    = 4'b0100;
    localparam logic [ALU_W-1:0] ALU_OR     = 4'b0101;
    localparam logic [ALU_W-1:0] ALU_XOR    = 4'b0110;
    localparam logic [ALU_W-1:0] ALU_XNOR   = 4'b0111;
    localparam logic [ALU_W-1:0] ALU_ANDN   = 4'b1000;
    localparam logic [ALU_W-1:0] ALU_ORN    = 4'b1001;
    localparam logic [ALU_W-1:0] ALU_SLL    = 4'b1010;
    localparam logic [ALU_W-1:0] ALU_SRL    = 4'b1011;
    localparam logic [ALU_W-1:0] ALU_SRA    = 4'b1100;
    localparam logic [ALU_W-1:0] ALU_PASS_B = 4'b1110;   // sethi forwards operand B

    // data memory access size
    localparam logic [SIZE_W-1:0] SIZE_BYTE = 2'b00;
    localparam logic [SIZE_W-1:0] SIZE_HALF = 2'b01;
    localparam logic [SIZE_W-1:0] SIZE_WORD = 2'b10;

    // call
    typedef struct packed {
        logic [OP_W-1:0]     op;
        logic [DISP30_W-1:0] disp30;
    } fmt1_t;

    // sethi and branches
    typedef struct packed {
        logic [OP_W-1:0]    op;
        logic [REG_W-1:0]   rd;      // a/cond on branches
        logic [OP2_W-1:0]   op2;
        logic [IMM22_W-1:0] imm22;
    } fmt2_t;

    // arithmetic, jmpl, save/restore and memory
    typedef struct packed {
        logic [OP_W-1:0]    op;
        logic [REG_W-1:0]   rd;
        logic [OP3_W-1:0]   op3;
        logic [REG_W-1:0]   rs1;
        logic               i;       // immediate select
        logic [LOW13_W-1:0] low13;   // simm13 or asi/rs2
    } fmt3_t;

    typedef union packed {
        fmt1_t fmt1;
        fmt2_t fmt2;
        fmt3_t fmt3;
    } instr_t;

    // control bundle handed to the next stage
    typedef struct packed {
        logic              jmpl;
        logic              call;
        logic              branch;
        logic              load;
        logic              rf_enable;
        logic              mem_se;
        logic              mem_rw;      // 1 = write
        logic              mem_enable;
        logic [SIZE_W-1:0] mem_size;
        logic              i31;
        logic              i30;
        logic              i24;
        logic              i13;
        logic [ALU_W-1:0]  alu_op;
        logic              cc_enable;
    } ctrl_t;

endpackage

/* testbench/control_unit_props.sv */
module control_unit_props import sparc_ctrl_pkg::*; (
    input logic  clk,
    input logic  reset,
    input logic  bubble,
    input ctrl_t ctrl
);

    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;   // read by the testbench at the end

    // reset leaves every field inactive
    reset_clears: assert property (@(posedge clk) reset |=> ctrl == '0)
        else begin
            $error("ctrl not cleared on the cycle after reset");
            failures = failures + 1;
        end

    bubble_squash: assert property (@(posedge clk) bubble |-> ctrl == '0)
        else begin
            $error("ctrl not zero while bubble is high");
            failures = failures + 1;
        end

    // a load never writes memory
    load_not_write: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.load && ctrl.mem_rw))
        else begin
            $error("load and mem_rw set together");
            failures = failures + 1;
        end

endmodule

bind control_unit control_unit_props u_props (
    .clk    (clk),
    .reset  (reset),
    .bubble (bubble),
    .ctrl   (ctrl)
);

/* testbench/control_unit_tb.sv */
module control_unit_tb import sparc_ctrl_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 20;
    localparam int MAX_INSTR  = 125;   // upper bound on applied instructions
    localparam int TIMEOUT    = MAX_INSTR * CLK_PERIOD * 4;

    logic   clk;
    logic   reset;
    logic   bubble;
    instr_t instr;
    ctrl_t  ctrl;

    integer seed;
    int     error_count;
    int     check_count;

    control_unit DUT (
        .clk    (clk),
        .reset  (reset),
        .instr  (instr),
        .bubble (bubble),
        .ctrl   (ctrl)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] random_word();
        logic [31:0] r;
        r = $random(seed);
        return r;
    endfunction

    // format 3 word with random rd, rs1, i and low bits
    function automatic logic [31:0] fmt3_word(logic [1:0] op, logic [5:0] op3);
        logic [31:0] w;
        w = random_word();
        w[31:30] = op;
        w[24:19] = op3;
        return w;
    endfunction

    // raw bits always follow the instruction word
    function automatic ctrl_t add_raw_bits(ctrl_t flags, logic [31:0] w);
        ctrl_t e;
        e = flags;
        e.i31 = w[31];
        e.i30 = w[30];
        e.i24 = w[24];
        e.i13 = w[13];
        return e;
    endfunction

    task automatic compare_bundle(string test, ctrl_t exp);
        check_count = check_count + 1;
        if (ctrl !== exp) begin
            $display("error %s: expected %h, actual %h", test, exp, ctrl);
            error_count = error_count + 1;
        end
    endtask

    task automatic check_bundle(string test, logic [31:0] w, ctrl_t flags);
        compare_bundle(test, add_raw_bits(flags, w));
    endtask

    task automatic apply(logic [31:0] w, logic b);
        @(posedge clk);
        #2;
        instr  = w;
        bubble = b;
    endtask

    // one instruction through the register, checked after the next edge
    task automatic run_instr(string test, logic [31:0] w, ctrl_t flags);
        apply(w, 1'b0);
        @(posedge clk);
        #1;
        check_bundle(test, w, flags);
    endtask

    task automatic test_reset_nop();
        ctrl_t flags;
        flags = '0;
        compare_bundle("reset", '0);
        run_instr("nop", 32'h0, flags);
    endtask

    task automatic test_arith_table();
        logic [5:0]  op3_tab [22];
        logic [3:0]  alu_tab [22];
        logic        cc_tab [22];
        logic [31:0] w;
        ctrl_t       flags;
        op3_tab = '{OP3_ADD, OP3_ADDCC, OP3_ADDX, OP3_ADDXCC, OP3_SUB, OP3_SUBCC,
                    OP3_SUBX, OP3_AND, OP3_ANDCC, OP3_ANDN, OP3_ANDNCC, OP3_OR,
                    OP3_ORCC, OP3_ORN, OP3_ORNCC, OP3_XOR, OP3_XORCC, OP3_XNOR,
                    OP3_XNORCC, OP3_SLL, OP3_SRL, OP3_SRA};
        alu_tab = '{ALU_ADD, ALU_ADD, ALU_ADDX, ALU_ADDX, ALU_SUB, ALU_SUB,
                    ALU_SUBX, ALU_AND, ALU_AND, ALU_ANDN, ALU_ANDN, ALU_OR,
                    ALU_OR, ALU_ORN, ALU_ORN, ALU_XOR, ALU_XOR, ALU_XNOR,
                    ALU_XNOR, ALU_SLL, ALU_SRL, ALU_SRA};
        cc_tab  = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1,
                    1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
        for (int k = 0; k < 22; k++) begin
            w = fmt3_word(OP_ARITH, op3_tab[k]);
            flags = '0;
            flags.alu_op    = alu_tab[k];
            flags.cc_enable = cc_tab[k];
            run_instr($sformatf("arith op3 %b", op3_tab[k]), w, flags);
        end
        // subxcc is not decoded, nor is 001101
        flags = '0;
        run_instr("arith subxcc", fmt3_word(OP_ARITH, 6'b011100), flags);
        run_instr("arith unlisted", fmt3_word(OP_ARITH, 6'b001101), flags);
    endtask

    task automatic test_mem_table();
        logic [5:0]  op3_tab [8];
        logic [1:0]  size_tab [8];
        logic        load_tab [8];
        logic        se_tab [8];
        ctrl_t       flags;
        op3_tab  = '{OP3_LDSB, OP3_LDSH, OP3_LD, OP3_LDUB, OP3_LDUH, OP3_STB, OP3_STH, OP3_ST};
        size_tab = '{SIZE_BYTE, SIZE_HALF, SIZE_WORD, SIZE_BYTE, SIZE_HALF,
                     SIZE_BYTE, SIZE_HALF, SIZE_WORD};
        load_tab = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0};
        se_tab   = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
        for (int k = 0; k < 8; k++) begin
            flags = '0;
            flags.mem_enable = 1'b1;
            flags.rf_enable  = 1'b1;
            flags.load       = load_tab[k];
            flags.mem_rw     = ~load_tab[k];   // stores write
            flags.mem_se     = se_tab[k];
            flags.mem_size   = size_tab[k];
            run_instr($sformatf("mem op3 %b", op3_tab[k]), fmt3_word(OP_MEM, op3_tab[k]), flags);
        end
        // ldd is not decoded here
        flags = '0;
        run_instr("mem unlisted", fmt3_word(OP_MEM, 6'b000011), flags);
    endtask

    task automatic test_control_transfer();
        logic [31:0] w;
        ctrl_t       flags;
        w = random_word();
        w[31:30] = OP_CALL;
        flags = '0;
        flags.call      = 1'b1;
        flags.rf_enable = 1'b1;
        run_instr("call", w, flags);

        w = random_word();
        w[31:30] = OP_BRANCH_SETHI;
        w[24:22] = OP2_SETHI;
        flags = '0;
        flags.alu_op = ALU_PASS_B;
        run_instr("sethi", w, flags);

        w[24:22] = OP2_BRANCH;
        flags = '0;
        flags.branch = 1'b1;
        run_instr("branch", w, flags);

        w[24:22] = 3'b110;   // not decoded here
        flags = '0;
        run_instr("unlisted op2", w, flags);

        flags = '0;
        flags.jmpl = 1'b1;
        run_instr("jmpl", fmt3_word(OP_ARITH, OP3_JMPL), flags);

        flags = '0;
        flags.rf_enable  = 1'b1;
        flags.mem_enable = 1'b1;
        flags.mem_size   = SIZE_WORD;
        run_instr("save", fmt3_word(OP_ARITH, OP3_SAVE), flags);
        run_instr("restore", fmt3_word(OP_ARITH, OP3_RESTORE), flags);
    endtask

    task automatic test_raw_bits();
        logic [31:0] w;
        logic [3:0]  exp_bits;
        logic [3:0]  got_bits;
        for (int k = 0; k < 16; k++) begin
            w = random_word();
            w[31] = 1'b1;   // op 10 or 11
            apply(w, 1'b0);
            @(posedge clk);
            #1;
            exp_bits = {w[31], w[30], w[24], w[13]};
            got_bits = {ctrl.i31, ctrl.i30, ctrl.i24, ctrl.i13};
            check_count = check_count + 1;
            if (got_bits !== exp_bits) begin
                $display("error raw bits %0d: expected %b, actual %b", k, exp_bits, got_bits);
                error_count = error_count + 1;
            end
        end
    endtask

    task automatic test_bubble();
        logic [31:0] w_a;
        logic [31:0] w_b;
        logic [31:0] w_c;
        ctrl_t       flags_a;
        ctrl_t       flags_c;
        w_a = fmt3_word(OP_ARITH, OP3_XOR);
        w_b = fmt3_word(OP_MEM, OP3_LD);
        w_c = fmt3_word(OP_ARITH, OP3_SUBCC);
        flags_a = '0;
        flags_a.alu_op = ALU_XOR;
        flags_c = '0;
        flags_c.alu_op    = ALU_SUB;
        flags_c.cc_enable = 1'b1;
        run_instr("bubble setup", w_a, flags_a);

        apply(w_b, 1'b1);
        #1;
        compare_bundle("bubble first cycle", '0);   // squashed without waiting for an edge
        apply(w_c, 1'b1);
        #1;
        compare_bundle("bubble second cycle", '0);
        apply(32'h0, 1'b0);
        #1;
        check_bundle("bubble released", w_c, flags_c);
    endtask

    initial begin
        #(TIMEOUT);
        $display("watchdog expired before the tests finished");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        bubble      = 1'b0;
        instr       = '0;
        seed        = 32'h40c9;
        error_count = 0;
        check_count = 0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        #1;

        test_reset_nop();
        test_arith_table();
        test_mem_table();
        test_control_transfer();
        test_raw_bits();
        test_bubble();

        @(posedge clk);
        #1;   // let the assertions of this edge settle
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, DUT.u_props.failures);
        if (error_count == 0 && DUT.u_props.failures == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
